//--- Makefile
VERILATOR  ?= verilator
TOP        ?= quad_dac_pmod_tb
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/dac_frame_if.sv
`default_nettype none

interface dac_frame_if;

    dac_pkg::dac_word_t words [dac_pkg::NUM_DAC];   // Latched words, one per DAC
    logic               frame_req;                  // Level, new data waiting
    logic               take;                       // One cycle, words copied
    logic               busy;                       // Frame in progress

    modport bank (
        output words,
        output frame_req,
        input  take
    );

    modport serializer (
        input  words,
        input  frame_req,
        output take,
        output busy
    );

endinterface

`default_nettype wire

//--- hw/dac_frame_serializer.sv
`default_nettype none

module dac_frame_serializer (
    input  logic                        PMD_clk,
    input  logic                        arst_n,
    dac_frame_if.serializer             frame,
    output logic                        dac_sclk,
    output logic                        dac_sync_n,
    output logic [dac_pkg::NUM_DAC-1:0] dac_sdin
);

    typedef logic [spi_pkg::BIT_CNT_WIDTH-1:0] bit_cnt_t;

    logic [1:0]            div_cnt;
    logic                  rise_stb;
    logic                  fall_stb;
    spi_pkg::frame_state_t state;
    bit_cnt_t              bit_cnt;
    logic                  sync_lvl;
    dac_pkg::dac_word_t    shadow [dac_pkg::NUM_DAC];

    //////////////////////////////
    // Serial clock
    //////////////////////////////

    // Strobes mark the cycle whose closing edge moves sclk
    assign rise_stb = (div_cnt == 2'(spi_pkg::SCLK_DIV / 2 - 1));
    assign fall_stb = (div_cnt == 2'(spi_pkg::SCLK_DIV - 1));

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt  <= '0;
            dac_sclk <= 1'b0;
        end
        else
        begin
            div_cnt <= div_cnt + 2'd1;
            if (rise_stb)
                dac_sclk <= 1'b1;
            else if (fall_stb)
                dac_sclk <= 1'b0;
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    assign frame.busy = (state != spi_pkg::idle);
    assign frame.take = fall_stb && frame.frame_req && !frame.busy;

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= spi_pkg::idle;
            bit_cnt  <= '0;
            sync_lvl <= 1'b1;
        end
        else if (fall_stb)
        begin
            case (state)
                spi_pkg::idle:
                begin
                    if (frame.take)
                    begin
                        bit_cnt <= bit_cnt_t'(spi_pkg::FRAME_BITS - 1);
                        state   <= spi_pkg::load;
                    end
                end
                spi_pkg::load:
                begin
                    sync_lvl <= 1'b0;   // Sync drops together with the MSB
                    state    <= spi_pkg::sync_lead;
                end
                spi_pkg::sync_lead:
                begin
                    bit_cnt <= bit_cnt - 1'b1;
                    state   <= spi_pkg::shift;
                end
                spi_pkg::shift:
                begin
                    if (bit_cnt == '0)
                    begin
                        sync_lvl <= 1'b1;   // LSB was the last bit clocked
                        state    <= spi_pkg::finish;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                spi_pkg::finish:
                    state <= spi_pkg::idle;
                default:
                    state <= spi_pkg::idle;
            endcase
        end
    end

    // Copy of the bank words for the whole frame
    always_ff @(posedge PMD_clk)
    begin
        if (frame.take)
            shadow <= frame.words;
    end

    //////////////////////////////
    // Output setup on rising sclk
    //////////////////////////////

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dac_sync_n <= 1'b1;
            dac_sdin   <= '0;
        end
        else if (rise_stb)
        begin
            dac_sync_n <= sync_lvl;
            for (int i = 0; i < dac_pkg::NUM_DAC; i++)
                dac_sdin[i] <= !sync_lvl && shadow[i].raw[bit_cnt];   // Quiet outside a frame
        end
    end

endmodule

`default_nettype wire

//--- hw/dac_pkg.sv
`default_nettype none

package dac_pkg;

    localparam int NUM_DAC        = 4;
    localparam int DAC_DATA_WIDTH = 20;
    localparam int DAC_WORD_WIDTH = 24;   // One serial word per DAC
    localparam int STREAM_WIDTH   = 32;   // Stream and config input width

    // Data register select in the address field
    localparam logic [2:0] DAC_REG_ADDR = 3'd1;

    // Register write word as the DAC decodes it
    typedef struct packed {
        logic                      rw;     // 0 selects a write
        logic [2:0]                addr;
        logic [DAC_DATA_WIDTH-1:0] data;
    } dac_fields_t;

    // Raw view for config writes and shifting, field view for stream samples
    typedef union packed {
        logic [DAC_WORD_WIDTH-1:0] raw;
        dac_fields_t               fields;
    } dac_word_t;

endpackage

`default_nettype wire

//--- hw/dac_word_bank.sv
`default_nettype none

module dac_word_bank (
    input  logic                             PMD_clk,
    input  logic                             arst_n,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data0,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data1,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data2,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data3,
    input  logic                             ch_valid0,
    input  logic                             ch_valid1,
    input  logic                             ch_valid2,
    input  logic                             ch_valid3,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] cfg_data,
    input  logic                             cfg_valid,
    input  logic                             cfg_mode,
    input  logic [1:0]                       cfg_axis,
    input  logic                             cfg_send,
    dac_frame_if.bank                        frame
);

    logic [dac_pkg::STREAM_WIDTH-1:0] ch_data [dac_pkg::NUM_DAC];
    logic [dac_pkg::NUM_DAC-1:0]      ch_valid;
    dac_pkg::dac_word_t               words_q    [dac_pkg::NUM_DAC];
    dac_pkg::dac_word_t               words_next [dac_pkg::NUM_DAC];
    logic                             changed;
    logic                             dirty;
    logic                             req_q;

    assign ch_data[0] = ch_data0;
    assign ch_data[1] = ch_data1;
    assign ch_data[2] = ch_data2;
    assign ch_data[3] = ch_data3;
    assign ch_valid   = {ch_valid3, ch_valid2, ch_valid1, ch_valid0};

    //////////////////////////////
    // Next word values
    //////////////////////////////

    always_comb
    begin
        words_next = words_q;
        if (cfg_mode)
        begin
            // Raw word straight into the selected channel
            if (cfg_valid)
                words_next[cfg_axis].raw = cfg_data[dac_pkg::DAC_WORD_WIDTH-1:0];
        end
        else
        begin
            for (int i = 0; i < dac_pkg::NUM_DAC; i++)
            begin
                if (ch_valid[i])
                begin
                    words_next[i].fields.rw   = 1'b0;
                    words_next[i].fields.addr = dac_pkg::DAC_REG_ADDR;
                    words_next[i].fields.data =
                        ch_data[i][dac_pkg::STREAM_WIDTH-1 -: dac_pkg::DAC_DATA_WIDTH];
                end
            end
        end

        changed = 1'b0;   // Only a real change asks for a frame
        for (int i = 0; i < dac_pkg::NUM_DAC; i++)
        begin
            if (words_next[i] != words_q[i])
                changed = 1'b1;
        end
    end

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < dac_pkg::NUM_DAC; i++)
                words_q[i] <= '0;
            dirty <= 1'b0;
            req_q <= 1'b0;
        end
        else
        begin
            words_q <= words_next;

            // A write racing the take keeps dirty for one more frame
            if (changed)
                dirty <= 1'b1;
            else if (frame.take)
                dirty <= 1'b0;

            if (frame.take)
                req_q <= 1'b0;
            else if (dirty && (!cfg_mode || cfg_send))
                req_q <= 1'b1;   // Sticky until the serializer takes
        end
    end

    assign frame.words     = words_q;
    assign frame.frame_req = req_q;

endmodule

`default_nettype wire

//--- hw/quad_dac_pmod_top.sv
`default_nettype none

module quad_dac_pmod_top (
    input  logic                             PMD_clk,
    input  logic                             arst_n,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data0,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data1,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data2,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] ch_data3,
    input  logic                             ch_valid0,
    input  logic                             ch_valid1,
    input  logic                             ch_valid2,
    input  logic                             ch_valid3,
    input  logic [dac_pkg::STREAM_WIDTH-1:0] cfg_data,
    input  logic                             cfg_valid,
    input  logic                             cfg_mode,
    input  logic [1:0]                       cfg_axis,
    input  logic                             cfg_send,
    output logic                             dac_sclk,
    output logic                             dac_sync_n,
    output logic [dac_pkg::NUM_DAC-1:0]      dac_sdin
);

    dac_frame_if frame_if ();

    // Stream and config latching
    dac_word_bank u_bank (
        .PMD_clk   (PMD_clk),
        .arst_n    (arst_n),
        .ch_data0  (ch_data0),
        .ch_data1  (ch_data1),
        .ch_data2  (ch_data2),
        .ch_data3  (ch_data3),
        .ch_valid0 (ch_valid0),
        .ch_valid1 (ch_valid1),
        .ch_valid2 (ch_valid2),
        .ch_valid3 (ch_valid3),
        .cfg_data  (cfg_data),
        .cfg_valid (cfg_valid),
        .cfg_mode  (cfg_mode),
        .cfg_axis  (cfg_axis),
        .cfg_send  (cfg_send),
        .frame     (frame_if.bank)
    );

    // Shared sync and sclk, one data line per DAC
    dac_frame_serializer u_serializer (
        .PMD_clk    (PMD_clk),
        .arst_n     (arst_n),
        .frame      (frame_if.serializer),
        .dac_sclk   (dac_sclk),
        .dac_sync_n (dac_sync_n),
        .dac_sdin   (dac_sdin)
    );

endmodule

`default_nettype wire

//--- hw/spi_pkg.sv
`default_nettype none

package spi_pkg;

    localparam int SCLK_DIV      = 4;    // PMD_clk cycles per sclk period
    localparam int FRAME_BITS    = 24;
    localparam int BIT_CNT_WIDTH = 5;

    // Serializer states, advanced on the falling sclk strobe
    typedef enum logic [2:0] {
        idle,
        load,
        sync_lead,
        shift,
        finish
    } frame_state_t;

endpackage

`default_nettype wire

//--- sim/quad_dac_pmod_props.sv
`default_nettype none

module quad_dac_pmod_props (
    input logic                        PMD_clk,
    input logic                        arst_n,
    input logic                        rise_stb,
    input logic                        dac_sclk,
    input logic                        dac_sync_n,
    input logic [dac_pkg::NUM_DAC-1:0] dac_sdin,
    input logic                        take,
    input logic                        busy
);

    int failures = 0;

    // Outputs register only on the rising strobe
    a_lines_on_rise: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        !$past(rise_stb) |-> $stable({dac_sync_n, dac_sdin}))
        else
        begin
            $error("sync or data changed away from the rising sclk strobe");
            failures++;
        end

    // Period of four with two cycles high
    a_sclk_pattern: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        $past(arst_n, 2) |-> dac_sclk != $past(dac_sclk, 2))
        else
        begin
            $error("sclk broke its two low and two high pattern");
            failures++;
        end

    // A take only from a quiet line, and the FSM turns busy right after it
    a_take_idle: assert property (@(posedge PMD_clk) disable iff (!arst_n)
        take |-> dac_sync_n ##1 busy)
        else
        begin
            $error("take raised outside idle or busy did not follow it");
            failures++;
        end

endmodule

bind dac_frame_serializer quad_dac_pmod_props u_props (
    .PMD_clk    (PMD_clk),
    .arst_n     (arst_n),
    .rise_stb   (rise_stb),
    .dac_sclk   (dac_sclk),
    .dac_sync_n (dac_sync_n),
    .dac_sdin   (dac_sdin),
    .take       (frame.take),
    .busy       (frame.busy)
);

`default_nettype wire

//--- sim/quad_dac_pmod_tb.sv
`default_nettype none

module quad_dac_pmod_tb;

    localparam int NUM_TESTS = 6;
    localparam int SETTLE    = 80;   // Cycles, well past any frame start

    logic                             PMD_clk;
    logic                             arst_n    = 1'b0;
    logic [dac_pkg::STREAM_WIDTH-1:0] ch_data [dac_pkg::NUM_DAC] = '{default: '0};
    logic [dac_pkg::NUM_DAC-1:0]      ch_valid  = '0;
    logic [dac_pkg::STREAM_WIDTH-1:0] cfg_data  = '0;
    logic                             cfg_valid = 1'b0;
    logic                             cfg_mode  = 1'b0;
    logic [1:0]                       cfg_axis  = '0;
    logic                             cfg_send  = 1'b0;
    logic                             dac_sclk;
    logic                             dac_sync_n;
    logic [dac_pkg::NUM_DAC-1:0]      dac_sdin;

    integer             seed = 32'h845068f8;
    int                 errors = 0;
    int                 tests_done = 0;
    int                 starts = 0;   // Falling sync edges
    int                 frames = 0;   // Complete 24-bit frames
    int                 bit_pos = 0;
    int                 mark [3];     // Errors, starts and frames when a test began
    dac_pkg::dac_word_t exp_words [dac_pkg::NUM_DAC] = '{default: '0};
    dac_pkg::dac_word_t cap_words [dac_pkg::NUM_DAC];
    dac_pkg::dac_word_t frame_log [$];   // NUM_DAC words per captured frame

    quad_dac_pmod_top dut (
        .ch_data0  (ch_data[0]),
        .ch_data1  (ch_data[1]),
        .ch_data2  (ch_data[2]),
        .ch_data3  (ch_data[3]),
        .ch_valid0 (ch_valid[0]),
        .ch_valid1 (ch_valid[1]),
        .ch_valid2 (ch_valid[2]),
        .ch_valid3 (ch_valid[3]),
        .*
    );

    initial
    begin
        PMD_clk = 1'b0;
        forever #50 PMD_clk = !PMD_clk;
    end

    //////////////////////////////
    // Frame capture, as a DAC sees it
    //////////////////////////////

    always @(negedge dac_sync_n)
        starts++;

    always @(negedge dac_sclk)
    begin
        if (!dac_sync_n)
        begin
            for (int i = 0; i < dac_pkg::NUM_DAC; i++)
                cap_words[i].raw = {cap_words[i].raw[22:0], dac_sdin[i]};   // MSB first
            bit_pos++;
            if (bit_pos == spi_pkg::FRAME_BITS)
            begin
                for (int i = 0; i < dac_pkg::NUM_DAC; i++)
                    frame_log.push_back(cap_words[i]);
                bit_pos = 0;
                frames++;
            end
        end
    end

    task automatic compare_word(input string what, input dac_pkg::dac_word_t got,
                                input dac_pkg::dac_word_t want);
        if (got !== want)
        begin
            $display("ERR %0t: %s got %06h expected %06h", $time, what, got.raw, want.raw);
            errors++;
        end
    endtask

    task automatic count_check(input string what, input int got, input int want);
        if (got != want)
        begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    // Frame index counts from the start of the current test
    task automatic frame_check(input int idx, input dac_pkg::dac_word_t want [dac_pkg::NUM_DAC]);
        for (int i = 0; i < dac_pkg::NUM_DAC; i++)
        begin
            if (frame_log.size() > (mark[2] + idx) * dac_pkg::NUM_DAC + i)
                compare_word($sformatf("frame %0d DAC %0d", idx, i),
                             frame_log[(mark[2] + idx) * dac_pkg::NUM_DAC + i], want[i]);
        end
    endtask

    // Random samples, same keeps the stored data bits
    task automatic stream_write(input logic [dac_pkg::NUM_DAC-1:0] mask, input bit same);
        logic [dac_pkg::STREAM_WIDTH-1:0] sample;
        @(posedge PMD_clk);
        for (int i = 0; i < dac_pkg::NUM_DAC; i++)
        begin
            sample = $random(seed);
            if (same)
                sample[31:12] = exp_words[i].fields.data;
            else if (sample[31:12] == exp_words[i].fields.data)
                sample[31] = !sample[31];   // Force a real change
            ch_data[i] <= sample;
            if (mask[i])
                exp_words[i] = {1'b0, dac_pkg::DAC_REG_ADDR, sample[31:12]};
        end
        ch_valid <= mask;
        @(posedge PMD_clk);
        ch_valid <= '0;
    endtask

    task automatic config_write(input logic [1:0] axis);
        logic [dac_pkg::STREAM_WIDTH-1:0] word;
        word = $random(seed);
        if (word[23:0] == exp_words[axis].raw)
            word[0] = !word[0];
        exp_words[axis].raw = word[23:0];
        @(posedge PMD_clk);
        cfg_data  <= word;
        cfg_axis  <= axis;
        cfg_valid <= 1'b1;
        @(posedge PMD_clk);
        cfg_valid <= 1'b0;
    endtask

    // Bounded wait, then a quiet spell to catch stray frames
    task automatic wait_frames(input int count);
        int n = 0;
        while (frames - mark[2] < count && n < 4 * 120)
        begin
            @(posedge PMD_clk);
            n++;
        end
        repeat (SETTLE) @(posedge PMD_clk);
    endtask

    task automatic end_test(input string name, input int want);
        count_check({name, ", frame starts"}, starts - mark[1], want);
        count_check({name, ", frames"}, frames - mark[2], want);
        tests_done++;
        $display("Test %0d %s: %s", tests_done, name, (errors == mark[0]) ? "ok" : "failed");
    endtask

    initial
    begin
        dac_pkg::dac_word_t snap [dac_pkg::NUM_DAC];
        logic [1:0]         ch;
        mark = '{errors, starts, frames};
        repeat (5) @(posedge PMD_clk);
        count_check("sclk, sync_n and sdin in reset",
                    int'({dac_sclk, dac_sync_n, dac_sdin}), int'(6'b010000));
        arst_n <= 1'b1;

        repeat (SETTLE) @(posedge PMD_clk);
        count_check("sync_n and sdin at rest", int'({dac_sync_n, dac_sdin}), int'(5'b10000));
        end_test("idle after reset", 0);

        mark = '{errors, starts, frames};
        ch = 2'($random(seed));
        stream_write(4'b0001 << ch, 1'b0);
        wait_frames(1);
        frame_check(0, exp_words);
        end_test("stream write to one channel", 1);

        mark = '{errors, starts, frames};
        stream_write(4'hf, 1'b0);
        wait_frames(1);
        frame_check(0, exp_words);
        end_test("stream write to all channels", 1);

        mark = '{errors, starts, frames};
        stream_write(4'hf, 1'b1);
        repeat (SETTLE) @(posedge PMD_clk);
        end_test("identical rewrite", 0);

        mark = '{errors, starts, frames};
        cfg_mode <= 1'b1;
        config_write(2'($random(seed)));
        repeat (SETTLE) @(posedge PMD_clk);
        count_check("starts before send", starts - mark[1], 0);
        cfg_send <= 1'b1;
        @(posedge PMD_clk);
        cfg_send <= 1'b0;
        wait_frames(1);
        frame_check(0, exp_words);
        cfg_mode <= 1'b0;
        end_test("config write with send", 1);

        mark = '{errors, starts, frames};
        stream_write(4'b0001 << ch, 1'b0);
        snap = exp_words;
        for (int n = 0; n < 120 && dac_sync_n; n++)
            @(posedge PMD_clk);
        stream_write(4'hf, 1'b0);   // Lands while sync is low
        wait_frames(2);
        frame_check(0, snap);
        frame_check(1, exp_words);
        end_test("write during a frame", 2);

        count_check("assertion failures", dut.u_serializer.u_props.failures, 0);
        $display("%0d tests, %0d errors", tests_done, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Four frames of 120 cycles per test plus margin
    initial
    begin
        repeat (NUM_TESTS * 4 * 120 + 1000) @(posedge PMD_clk);
        $display("Timeout, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/dac_pkg.sv
hw/spi_pkg.sv
hw/dac_frame_if.sv
hw/dac_word_bank.sv
hw/dac_frame_serializer.sv
hw/quad_dac_pmod_top.sv
sim/quad_dac_pmod_props.sv
sim/quad_dac_pmod_tb.sv
